//--- tb.f
src/codec_cfg_pkg.sv
src/i2c_bit_if.sv
src/codec_cfg_rom.sv
src/i2c_phase_timer.sv
src/i2c_byte_shifter.sv
src/i2c_init_fsm.sv
src/codec_i2c_init.sv
tb/i2c_codec_model.sv
tb/tb_codec_i2c_init.sv

//--- Makefile
# Verilator build and run for the codec I2C init testbench

VERILATOR ?= verilator
TOP       ?= tb_codec_i2c_init
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TEST RESULT: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/tb_codec_i2c_init.sv
`timescale 1ns/100ps
`default_nettype none

module tb_codec_i2c_init
    import codec_cfg_pkg::*;
();

    // One write is a start, three bytes of nine bits in two phases each, and a two phase stop
    localparam int FRAME_PHASES = 1 + BYTES_PER_CMD * 2 * (BITS_PER_BYTE + 1) + 2;
    localparam int RUN_CLKS     = CMD_COUNT * FRAME_PHASES * PHASE_CLKS;
    localparam int TIMEOUT_CLKS = RUN_CLKS + 16 * PHASE_CLKS;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        start;
    logic        sda_line;
    logic        sclk;
    logic        sdat;
    logic        oen;
    logic        finished;
    logic        ack_error;
    int          nack_frame;
    logic [31:0] lcg_state;
    int          checks;
    int          value_errors;
    int          other_errors;

    string     row_name[$];
    int        row_nack[$];     // Table index without ACK, -1 for none
    int        row_err[$];
    cmd_word_t exp_words[$];

    always #4 clk = ~clk;

    codec_i2c_init codec_i2c_init_i (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_start     (start),
        .i_sdat_in   (sda_line),
        .o_sclk      (sclk),
        .o_sdat      (sdat),
        .o_oen       (oen),
        .o_finished  (finished),
        .o_ack_error (ack_error)
    );

    i2c_codec_model model_i (
        .i_rst_n      (rst_n),
        .i_sclk       (sclk),
        .i_sdat       (sdat),
        .i_oen        (oen),
        .i_nack_frame (nack_frame),
        .o_sda        (sda_line)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic add_write(input logic [REG_ADDR_W-1:0] reg_addr,
                             input logic [REG_DATA_W-1:0] reg_data);
        cmd_word_t w;
        w.f.dev_addr = CODEC_ADDR;
        w.f.reg_addr = reg_addr;
        w.f.reg_data = reg_data;
        exp_words.push_back(w);
    endtask

    task automatic add_row(input string name, input int nack_idx, input int exp_err);
        row_name.push_back(name);
        row_nack.push_back(nack_idx);
        row_err.push_back(exp_err);
    endtask

    task automatic expect_equal(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        checks++;
        assert (actual == expected) else begin
            value_errors++;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic expect_true(input bit ok, input string failure);
        checks++;
        assert (ok) else begin
            other_errors++;
            $display("%s", failure);
        end
    endtask

    // Bus idle, SCL parked high, finish flag held
    task automatic idle_gap(input string name, input int gap, input logic exp_finished);
        for (int i = 0; i < gap; i++) begin
            @(negedge clk);
            expect_equal({name, " idle o_finished"}, 32'(exp_finished), 32'(finished));
            expect_equal({name, " idle o_sclk"}, 32'd1, 32'(sclk));
        end
    endtask

    task automatic pulse_start();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_finished(output int clocks, output bit timed_out);
        clocks = 0;
        while (finished !== 1'b1 && clocks < TIMEOUT_CLKS) begin
            @(negedge clk);
            clocks++;
        end
        timed_out = (finished !== 1'b1);
    endtask

    task automatic run_row(input int r);
        string name;
        int    base;
        int    bus_base;
        int    oen_base;
        int    gap;
        int    clocks;
        int    got;
        bit    timed_out;
        name       = row_name[r];
        base       = model_i.rx_count;
        bus_base   = model_i.bus_errors;
        oen_base   = model_i.oen_errors;
        nack_frame = (row_nack[r] < 0) ? -1 : base + row_nack[r];
        lcg_state  = lcg_next(lcg_state);
        gap        = 2 + int'(lcg_state[18:16]);
        idle_gap(name, gap, r > 0);
        pulse_start();
        expect_equal({name, " o_finished after start"}, 32'd0, 32'(finished));
        expect_equal({name, " o_ack_error after start"}, 32'd0, 32'(ack_error));
        wait_finished(clocks, timed_out);
        expect_true(!timed_out, $sformatf("%s: o_finished did not rise within %0d clocks",
                                          name, TIMEOUT_CLKS));
        if (!timed_out) begin
            expect_equal({name, " latency"}, 32'(RUN_CLKS), 32'(clocks));
        end
        got = model_i.rx_count - base;
        expect_equal({name, " write count"}, 32'(CMD_COUNT), 32'(got));
        for (int k = 0; k < got && k < CMD_COUNT; k++) begin
            expect_equal($sformatf("%s write %0d", name, k), 32'(exp_words[k].raw),
                         32'(model_i.rx_words[base + k]));
        end
        expect_true(model_i.bus_errors == bus_base,
                    $sformatf("%s: start or stop out of place, or SDA moved while SCL high", name));
        expect_true(model_i.oen_errors == oen_base,
                    $sformatf("%s: SDA released outside an ACK bit, or held in one", name));
        expect_equal({name, " o_ack_error"}, 32'(row_err[r]), 32'(ack_error));
    endtask

    initial begin
        rst_n        = 1'b0;
        start        = 1'b0;
        nack_frame   = -1;
        lcg_state    = 32'hd2a9fc17;
        checks       = 0;
        value_errors = 0;
        other_errors = 0;

        add_write(7'h0f, 9'h000);   // Reset
        add_write(7'h04, 9'h015);   // Analogue path
        add_write(7'h05, 9'h000);   // Digital path
        add_write(7'h06, 9'h000);   // Power down
        add_write(7'h07, 9'h042);   // Interface format
        add_write(7'h08, 9'h019);   // Sampling
        add_write(7'h09, 9'h001);   // Active control

        add_row("all_acked", -1, 0);
        add_row("nack_first_write", 0, 1);
        add_row("clean_restart", -1, 0);
        add_row("nack_last_write", CMD_COUNT - 1, 1);
        add_row("nack_middle_write", 3, 1);

        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        expect_equal("reset o_sclk", 32'd1, 32'(sclk));
        expect_equal("reset o_sdat", 32'd1, 32'(sdat));
        expect_equal("reset o_oen", 32'd1, 32'(oen));
        expect_equal("reset o_finished", 32'd0, 32'(finished));
        expect_equal("reset o_ack_error", 32'd0, 32'(ack_error));

        for (int r = 0; r < row_name.size(); r++) begin
            run_row(r);
        end
        idle_gap("final_hold", 4, 1'b1);

        $display("Checks: %0d, value errors: %0d, other failures: %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/i2c_codec_model.sv
`timescale 1ns/100ps
`default_nettype none

module i2c_codec_model
    import codec_cfg_pkg::*;
(
    input  logic i_rst_n,
    input  logic i_sclk,
    input  logic i_sdat,
    input  logic i_oen,
    input  int   i_nack_frame,  // Frame number left unacknowledged, -1 for none
    output logic o_sda          // Resolved open-drain data line
);

    logic                ack_pull;
    logic                prev_scl;
    logic                prev_sda;
    logic                in_frame;
    logic                in_ack;
    logic                withhold;
    int                  bit_cnt;
    int                  byte_cnt;
    logic [CMD_BITS-1:0] shift_word;
    logic [CMD_BITS-1:0] rx_words[$];   // Every complete write, oldest first
    int                  rx_count;
    int                  bus_errors;
    int                  oen_errors;

    // Pull-up wins unless the master or the codec drives low
    assign o_sda = !((i_oen && !i_sdat) || ack_pull);

    task automatic clear_state();
        in_frame = 1'b0;
        in_ack   = 1'b0;
        ack_pull = 1'b0;
        bit_cnt  = 0;
        byte_cnt = 0;
    endtask

    task automatic on_scl_rise();
        if (in_frame) begin
            if (in_ack) begin
                if (i_oen) begin
                    oen_errors++;       // Master still owns SDA in the ACK bit
                end
            end else begin
                if (!i_oen) begin
                    oen_errors++;
                end
                // Past the third byte this rise belongs to the stop
                if (byte_cnt < BYTES_PER_CMD) begin
                    shift_word = {shift_word[CMD_BITS-2:0], o_sda};
                end
                bit_cnt++;
            end
        end
    endtask

    task automatic on_scl_fall();
        if (in_frame) begin
            if (in_ack) begin
                in_ack   = 1'b0;
                ack_pull = 1'b0;
                bit_cnt  = 0;
                byte_cnt++;
            end else if (bit_cnt == BITS_PER_BYTE) begin
                in_ack   = 1'b1;
                ack_pull = !withhold;
            end
        end
    endtask

    task automatic on_start();
        if (in_frame || !i_oen) begin
            bus_errors++;
        end
        clear_state();
        in_frame   = 1'b1;
        shift_word = '0;
        withhold   = (rx_count == i_nack_frame);
    endtask

    task automatic on_stop();
        if (in_frame && !in_ack && byte_cnt == BYTES_PER_CMD && bit_cnt == 1 && i_oen) begin
            rx_words.push_back(shift_word);
            rx_count++;
        end else begin
            bus_errors++;
        end
        clear_state();
    endtask

    initial begin
        clear_state();
        withhold   = 1'b0;
        shift_word = '0;
        prev_scl   = 1'b1;
        prev_sda   = 1'b1;
        rx_count   = 0;
        bus_errors = 0;
        oen_errors = 0;
        forever begin
            @(i_sclk or o_sda or i_rst_n);
            if (!i_rst_n) begin
                clear_state();
            end else if (i_sclk === 1'b1 && prev_scl === 1'b0) begin
                on_scl_rise();
            end else if (i_sclk === 1'b0 && prev_scl === 1'b1) begin
                on_scl_fall();
            end else if (i_sclk === 1'b1 && prev_scl === 1'b1 && o_sda !== prev_sda) begin
                // SDA edge with SCL high frames a transfer
                if (o_sda === 1'b0) begin
                    on_start();
                end else if (o_sda === 1'b1) begin
                    on_stop();
                end
            end
            prev_scl = i_sclk;
            prev_sda = o_sda;
        end
    end

endmodule

`default_nettype wire

//--- src/codec_i2c_init.sv
`timescale 1ns/100ps
`default_nettype none

module codec_i2c_init
    import codec_cfg_pkg::*;
(
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_start,
    input  logic i_sdat_in,     // Resolved SDA level
    output logic o_sclk,
    output logic o_sdat,
    output logic o_oen,         // Low while the codec owns SDA
    output logic o_finished,
    output logic o_ack_error
);

    i2c_bit_if bus ();

    logic [CMD_IDX_W-1:0] cmd_index;
    cmd_word_t            rom_cmd;
    cmd_word_t            load_word;
    logic                 start_sda;
    logic                 sda_force;

    i2c_init_fsm fsm_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .bus         (bus.fsm_mp),
        .o_cmd_index (cmd_index),
        .i_cmd       (rom_cmd),
        .o_load_word (load_word),
        .o_sclk      (o_sclk),
        .o_start_sda (start_sda),
        .o_sda_force (sda_force),
        .o_finished  (o_finished)
    );

    i2c_phase_timer timer_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .bus     (bus.timer_mp)
    );

    i2c_byte_shifter shifter_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .bus         (bus.shift_mp),
        .i_word      (load_word),
        .i_sda_force (sda_force),
        .i_start_sda (start_sda),
        .i_sdat_in   (i_sdat_in),
        .o_sdat      (o_sdat),
        .o_oen       (o_oen),
        .o_ack_error (o_ack_error)
    );

    codec_cfg_rom rom_i (
        .i_index (cmd_index),
        .o_cmd   (rom_cmd)
    );

endmodule

`default_nettype wire

//--- src/i2c_init_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module i2c_init_fsm
    import codec_cfg_pkg::*;
(
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_start,
    i2c_bit_if.fsm_mp            bus,
    output logic [CMD_IDX_W-1:0] o_cmd_index,
    input  cmd_word_t            i_cmd,
    output cmd_word_t            o_load_word,
    output logic                 o_sclk,
    output logic                 o_start_sda,
    output logic                 o_sda_force,
    output logic                 o_finished
);

    logic [STATE_W-1:0]    state_r;
    logic [STATE_W-1:0]    state_n;
    logic [CMD_IDX_W-1:0]  cmd_idx_r;
    logic [CMD_IDX_W-1:0]  cmd_idx_n;
    logic [BYTE_CNT_W-1:0] byte_cnt_r;
    logic [BYTE_CNT_W-1:0] byte_cnt_n;
    logic                  finished_r;
    logic                  finished_n;
    logic                  sclk_r;
    logic                  sclk_n;

    assign o_cmd_index = cmd_idx_r;
    assign o_load_word = i_cmd;
    assign o_sclk      = sclk_r;
    assign o_finished  = finished_r;

    assign bus.ack_slot = (state_r == ST_ACK_LO) || (state_r == ST_ACK_HI);
    assign o_sda_force  = state_r inside {ST_IDLE, ST_START, ST_STOP_LO, ST_STOP_HI, ST_DONE};
    // Low for start and the first half of stop, high otherwise
    assign o_start_sda  = !(state_r inside {ST_START, ST_STOP_LO});

    assign sclk_n = !(state_n inside {ST_BIT_LO, ST_ACK_LO, ST_STOP_LO});

    always_comb begin
        state_n         = state_r;
        cmd_idx_n       = cmd_idx_r;
        byte_cnt_n      = byte_cnt_r;
        finished_n      = finished_r;
        bus.phase_start = 1'b0;
        bus.bit_clear   = 1'b0;
        bus.bit_step    = 1'b0;
        bus.load        = 1'b0;
        bus.shift       = 1'b0;
        bus.ack_sample  = 1'b0;
        case (state_r)
            ST_IDLE, ST_DONE: begin
                if (i_start) begin
                    state_n         = ST_START;
                    cmd_idx_n       = '0;
                    finished_n      = 1'b0;
                    bus.phase_start = 1'b1;
                end
            end
            ST_START: begin
                if (bus.phase_end) begin
                    state_n         = ST_BIT_LO;
                    byte_cnt_n      = '0;
                    bus.bit_clear   = 1'b1;
                    bus.load        = 1'b1;     // Table entry for cmd_idx_r
                    bus.phase_start = 1'b1;
                end
            end
            ST_BIT_LO: begin
                if (bus.phase_end) begin
                    state_n         = ST_BIT_HI;
                    bus.bit_step    = 1'b1;
                    bus.phase_start = 1'b1;
                end
            end
            ST_BIT_HI: begin
                if (bus.phase_end) begin
                    state_n         = bus.byte_done ? ST_ACK_LO : ST_BIT_LO;
                    bus.shift       = 1'b1;
                    bus.phase_start = 1'b1;
                end
            end
            ST_ACK_LO: begin
                if (bus.phase_end) begin
                    state_n         = ST_ACK_HI;
                    bus.phase_start = 1'b1;
                end
            end
            ST_ACK_HI: begin
                if (bus.phase_end) begin
                    bus.ack_sample  = 1'b1;     // End of SCL high
                    bus.bit_clear   = 1'b1;
                    bus.phase_start = 1'b1;
                    if (byte_cnt_r == BYTE_CNT_W'(BYTES_PER_CMD - 1)) begin
                        state_n = ST_STOP_LO;
                    end else begin
                        state_n    = ST_BIT_LO;
                        byte_cnt_n = byte_cnt_r + 1'b1;
                    end
                end
            end
            ST_STOP_LO: begin
                if (bus.phase_end) begin
                    state_n         = ST_STOP_HI;
                    bus.phase_start = 1'b1;
                end
            end
            ST_STOP_HI: begin
                if (bus.phase_end) begin
                    if (cmd_idx_r == CMD_IDX_W'(CMD_COUNT - 1)) begin
                        state_n    = ST_DONE;
                        finished_n = 1'b1;
                    end else begin
                        state_n         = ST_START;
                        cmd_idx_n       = cmd_idx_r + 1'b1;
                        bus.phase_start = 1'b1;
                    end
                end
            end
            default: state_n = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_r    <= ST_IDLE;
            cmd_idx_r  <= '0;
            byte_cnt_r <= '0;
            finished_r <= 1'b0;
            sclk_r     <= 1'b1;
        end else begin
            state_r    <= state_n;
            cmd_idx_r  <= cmd_idx_n;
            byte_cnt_r <= byte_cnt_n;
            finished_r <= finished_n;
            sclk_r     <= sclk_n;               // Registered so SCL is glitch free
        end
    end

endmodule

`default_nettype wire

//--- src/i2c_byte_shifter.sv
`timescale 1ns/100ps
`default_nettype none

module i2c_byte_shifter
    import codec_cfg_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  logic         i_start,
    i2c_bit_if.shift_mp  bus,
    input  cmd_word_t    i_word,
    input  logic         i_sda_force,
    input  logic         i_start_sda,
    input  logic         i_sdat_in,
    output logic         o_sdat,
    output logic         o_oen,
    output logic         o_ack_error
);

    cmd_word_t word_r;
    logic      sdat_r;
    logic      oen_r;
    logic      ack_error_r;

    assign o_sdat      = sdat_r;
    assign o_oen       = oen_r;
    assign o_ack_error = ack_error_r;

    // Command word, MSB leaves first
    always_ff @(posedge i_clk) begin
        if (bus.load) begin
            word_r <= i_word;
        end else if (bus.shift) begin
            word_r.raw <= {word_r.raw[CMD_BITS-2:0], 1'b0};
        end
    end

    // Line drivers trail SCL by one clock, so SDA
    // never moves on the same edge as SCL
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            sdat_r <= 1'b1;
            oen_r  <= 1'b1;
        end else begin
            sdat_r <= i_sda_force ? i_start_sda : word_r.raw[CMD_BITS-1];
            oen_r  <= ~bus.ack_slot;            // Release for the codec ACK
        end
    end

    // Acknowledge capture and sticky error
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            bus.nack    <= 1'b0;
            ack_error_r <= 1'b0;
        end else if (i_start) begin
            bus.nack    <= 1'b0;
            ack_error_r <= 1'b0;
        end else begin
            if (bus.ack_sample) begin
                bus.nack <= i_sdat_in;          // High means no ACK
            end
            if (bus.nack) begin
                ack_error_r <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/i2c_phase_timer.sv
`timescale 1ns/100ps
`default_nettype none

module i2c_phase_timer
    import codec_cfg_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_rst_n,
    i2c_bit_if.timer_mp  bus
);

    logic [PHASE_CNT_W-1:0] phase_cnt_r;
    logic                   running_r;
    logic [BIT_CNT_W-1:0]   bit_cnt_r;
    logic                   last_clk;

    assign last_clk      = (phase_cnt_r == PHASE_CNT_W'(PHASE_CLKS - 1));
    assign bus.phase_end = running_r && last_clk;
    assign bus.byte_done = (bit_cnt_r == BIT_CNT_W'(BITS_PER_BYTE));

    // Phase counter, restarted by each new phase
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            phase_cnt_r <= '0;
            running_r   <= 1'b0;
        end else if (bus.phase_start) begin
            phase_cnt_r <= '0;
            running_r   <= 1'b1;
        end else if (bus.phase_end) begin
            running_r   <= 1'b0;                // No follow-on phase
        end else if (running_r) begin
            phase_cnt_r <= phase_cnt_r + 1'b1;
        end
    end

    // Bits of the current byte, holds at eight
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            bit_cnt_r <= '0;
        end else if (bus.bit_clear) begin
            bit_cnt_r <= '0;
        end else if (bus.bit_step && !bus.byte_done) begin
            bit_cnt_r <= bit_cnt_r + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- src/codec_cfg_rom.sv
`timescale 1ns/100ps
`default_nettype none

module codec_cfg_rom
    import codec_cfg_pkg::*;
(
    input  logic [CMD_IDX_W-1:0] i_index,
    output cmd_word_t            o_cmd
);

    function automatic cmd_word_t make_cmd(
        input logic [REG_ADDR_W-1:0] reg_addr,
        input logic [REG_DATA_W-1:0] reg_data
    );
        cmd_word_t cmd;
        cmd.f.dev_addr = CODEC_ADDR;
        cmd.f.reg_addr = reg_addr;
        cmd.f.reg_data = reg_data;
        return cmd;
    endfunction

    always_comb begin
        case (i_index)
            3'd0:    o_cmd = make_cmd(7'h0f, 9'h000);   // Reset
            3'd1:    o_cmd = make_cmd(7'h04, 9'h015);   // Analogue path, DAC selected
            3'd2:    o_cmd = make_cmd(7'h05, 9'h000);   // Digital path
            3'd3:    o_cmd = make_cmd(7'h06, 9'h000);   // Power down, all on
            3'd4:    o_cmd = make_cmd(7'h07, 9'h042);   // Interface format
            3'd5:    o_cmd = make_cmd(7'h08, 9'h019);   // Sampling
            3'd6:    o_cmd = make_cmd(7'h09, 9'h001);   // Active control
            // Unused slot
            default: o_cmd = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/i2c_bit_if.sv
`timescale 1ns/100ps
`default_nettype none

interface i2c_bit_if;

    logic phase_start;
    logic phase_end;
    logic bit_clear;
    logic bit_step;
    logic byte_done;
    logic load;
    logic shift;
    logic ack_slot;
    logic ack_sample;
    logic nack;

    modport fsm_mp (
        output phase_start, bit_clear, bit_step, load, shift, ack_slot, ack_sample,
        input  phase_end, byte_done
    );

    modport timer_mp (
        input  phase_start, bit_clear, bit_step,
        output phase_end, byte_done
    );

    modport shift_mp (
        input  load, shift, ack_slot, ack_sample,
        output nack
    );

endinterface

`default_nettype wire

//--- src/codec_cfg_pkg.sv
`default_nettype none

package codec_cfg_pkg;

    // Table and word geometry
    localparam int CMD_COUNT     = 7;
    localparam int CMD_BITS      = 24;
    localparam int BYTES_PER_CMD = 3;
    localparam int BITS_PER_BYTE = 8;

    localparam int DEV_ADDR_W = 8;
    localparam int REG_ADDR_W = 7;
    localparam int REG_DATA_W = 9;

    // System clocks per half SCL period
    localparam int PHASE_CLKS = 4;

    localparam logic [DEV_ADDR_W-1:0] CODEC_ADDR = 8'h34;   // Write address, R/W bit low

    // Counter widths
    localparam int CMD_IDX_W   = $clog2(CMD_COUNT);
    localparam int BYTE_CNT_W  = $clog2(BYTES_PER_CMD);
    localparam int BIT_CNT_W   = $clog2(BITS_PER_BYTE + 1);
    localparam int PHASE_CNT_W = (PHASE_CLKS > 1) ? $clog2(PHASE_CLKS) : 1;

    // Sequencer states
    localparam int STATE_W = 4;
    localparam logic [STATE_W-1:0] ST_IDLE    = 4'd0;
    localparam logic [STATE_W-1:0] ST_START   = 4'd1;
    localparam logic [STATE_W-1:0] ST_BIT_LO  = 4'd2;
    localparam logic [STATE_W-1:0] ST_BIT_HI  = 4'd3;
    localparam logic [STATE_W-1:0] ST_ACK_LO  = 4'd4;
    localparam logic [STATE_W-1:0] ST_ACK_HI  = 4'd5;
    localparam logic [STATE_W-1:0] ST_STOP_LO = 4'd6;
    localparam logic [STATE_W-1:0] ST_STOP_HI = 4'd7;
    localparam logic [STATE_W-1:0] ST_DONE    = 4'd8;

    // Top data bit rides in the register address byte
    typedef struct packed {
        logic [DEV_ADDR_W-1:0] dev_addr;
        logic [REG_ADDR_W-1:0] reg_addr;
        logic [REG_DATA_W-1:0] reg_data;
    } cmd_fields_t;

    typedef union packed {
        logic [CMD_BITS-1:0] raw;   // Sent MSB first
        cmd_fields_t         f;
    } cmd_word_t;

endpackage

`default_nettype wire
